// File: build.f
logic/sprite_pkg.sv
logic/sprite_regs_apb.sv
logic/sprite_scanner.sv
logic/pixel_writer.sv
logic/line_buffer.sv
logic/sprite_engine.sv
tb/sprite_engine_assert.sv
tb/sprite_engine_tb.sv

// File: run.sh
#!/bin/sh
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
	--top-module sprite_engine_tb -f build.f -o sim_tb > build.log 2>&1 \
	&& ./obj_dir/sim_tb > sim.log 2>&1 \
	|| { cat build.log; echo "CHECKS FAILED" >> sim.log; }
cat sim.log
grep -q "CHECKS FAILED" sim.log && exit 1 || exit 0

// File: tb/sprite_engine_tb.sv
`timescale 1ns/100ps

module sprite_engine_tb
	import sprite_pkg::*;
();

	localparam int NUM_SPRITES = DEFAULT_NUM_SPRITES;
	localparam int LINE_WIDTH = DEFAULT_LINE_WIDTH;
	localparam int N_PAT = 2**PAT_ADDR_W;
	localparam int N_PAL = 2**PIX_W;
	localparam int N_BAD = 6;
	localparam int RAND_SCENES = 4;
	localparam int RAND_LINES = 8;

	// Run length covers every scene load, the readback and two renders per observed line
	localparam int SCENE_XFERS = NUM_SPRITES + N_PAT + N_PAL;
	localparam int N_XFERS = (4 + RAND_SCENES) * SCENE_XFERS + SCENE_XFERS + 2 * N_BAD;
	localparam int N_LINES = 2 * (10 + 8 + 8 + RAND_SCENES * RAND_LINES);
	localparam int LIMIT = (N_LINES * 300 + N_XFERS * 3) * 2;

	logic clk;
	logic reset;
	apb_req_t apb_req;
	apb_rsp_t apb_rsp;
	logic line_start;
	logic [POS_W-1:0] line_y;
	logic busy;
	logic [POS_W-1:0] disp_x;
	logic [COLOR_W-1:0] disp_color;

	integer seed = 54279;
	int cycles = 0;

	// Reference copies of the three memories and the expected line
	sprite_attr_t m_attr [NUM_SPRITES];
	logic [31:0] m_pat [N_PAT];
	logic [COLOR_W-1:0] m_pal [N_PAL];
	logic [COLOR_W-1:0] exp_line [LINE_WIDTH];

	sprite_engine #(
		.NUM_SPRITES(NUM_SPRITES),
		.LINE_WIDTH(LINE_WIDTH)
	) i_sprite_engine (
		.clk, .reset, .apb_req, .apb_rsp, .line_start, .line_y, .busy, .disp_x, .disp_color
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycles = cycles + 1;
		if (cycles >= LIMIT)
			stop_run($sformatf("Timeout: run did not finish within %0d cycles", LIMIT));
	end

	task automatic stop_run(input string msg);
		$display("%s", msg);
		$display("CHECKS FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_color(input string name, input logic [COLOR_W-1:0] got,
			input logic [COLOR_W-1:0] exp);
		if (got !== exp)
			stop_run($sformatf("Fail %s: got 0x%h, expected 0x%h", name, got, exp));
	endtask

	task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
			stop_run($sformatf("Fail %s: got 0x%h, expected 0x%h", name, got, exp));
	endtask

	task automatic check_err(input string name, input logic got, input logic exp);
		if (got !== exp)
			stop_run($sformatf("Fail %s: got 0x%h, expected 0x%h", name, got, exp));
	endtask

	task automatic check_ready(input string name, input logic got, input logic exp);
		if (got !== exp)
			stop_run($sformatf("Fail %s: got 0x%h, expected 0x%h", name, got, exp));
	endtask

	function automatic logic [31:0] rand32();
		return $random(seed);
	endfunction

	function automatic int rnd_range(input int n);
		logic [31:0] r;
		r = rand32();
		return int'(r % n);
	endfunction

	// Random row with roughly half of the pixels transparent
	function automatic logic [31:0] random_row();
		logic [31:0] row;
		logic [31:0] mask;
		row = rand32();
		mask = rand32();
		for (int c = 0; c < SPRITE_SIZE; c++)
			if (mask[c])
				row[c*PIX_W +: PIX_W] = '0;
		return row;
	endfunction

	function automatic void random_assets();
		logic [31:0] r;
		for (int i = 0; i < N_PAT; i++)
			m_pat[i] = random_row();
		for (int i = 0; i < N_PAL; i++)
		begin
			r = rand32();
			m_pal[i] = r[COLOR_W-1:0];
		end
	endfunction

	function automatic void random_attrs();
		logic [31:0] r;
		for (int i = 0; i < NUM_SPRITES; i++)
		begin
			r = rand32();
			m_attr[i] = r[15:0];
		end
	endfunction

	function automatic void clear_attrs();
		for (int i = 0; i < NUM_SPRITES; i++)
			m_attr[i] = '0;
	endfunction

	// Paint in index order so later sprites overwrite earlier ones
	function automatic void paint_line(input int y);
		int ax;
		int ay;
		int row;
		int src;
		int px;
		logic [PIX_W-1:0] pix;
		for (int i = 0; i < LINE_WIDTH; i++)
			exp_line[i] = '0;
		for (int s = 0; s < NUM_SPRITES; s++)
		begin
			ax = int'(m_attr[s].x);
			ay = int'(m_attr[s].y);
			if (m_attr[s].enable && y >= ay && y < ay + SPRITE_SIZE)
			begin
				row = y - ay;
				for (int c = 0; c < SPRITE_SIZE; c++)
				begin
					src = m_attr[s].mirror ? SPRITE_SIZE - 1 - c : c;
					pix = m_pat[int'(m_attr[s].image) * SPRITE_SIZE + row][src*PIX_W +: PIX_W];
					px = ax + c;
					if (pix != 0 && px < LINE_WIDTH)
						exp_line[px] = m_pal[pix];
				end
			end
		end
	endfunction

	task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
			output logic [31:0] rdata, output logic err);
		@(negedge clk);
		apb_req.psel = 1'b1;
		apb_req.penable = 1'b0;
		apb_req.pwrite = wr;
		apb_req.paddr = addr;
		apb_req.pwdata = wdata;
		@(negedge clk);
		apb_req.penable = 1'b1;
		// Response settles well before the completing edge
		#10;
		rdata = apb_rsp.prdata;
		err = apb_rsp.pslverr;
		check_ready($sformatf("pready 0x%h", addr), apb_rsp.pready, 1'b1);
		@(negedge clk);
		apb_req = '0;
	endtask

	task automatic apb_write(input logic [7:0] addr, input logic [31:0] wdata);
		logic [31:0] rd;
		logic err;
		apb_xfer(1'b1, addr, wdata, rd, err);
		check_err($sformatf("pslverr write 0x%h", addr), err, 1'b0);
	endtask

	task automatic apb_read(input logic [7:0] addr, output logic [31:0] rd);
		logic err;
		apb_xfer(1'b0, addr, '0, rd, err);
		check_err($sformatf("pslverr read 0x%h", addr), err, 1'b0);
	endtask

	task automatic load_scene();
		for (int i = 0; i < NUM_SPRITES; i++)
			apb_write(ATTR_BASE + 8'(i), 32'(m_attr[i]));
		for (int i = 0; i < N_PAT; i++)
			apb_write(PAT_BASE + 8'(i), m_pat[i]);
		for (int i = 0; i < N_PAL; i++)
			apb_write(PAL_BASE + 8'(i), 32'(m_pal[i]));
	endtask

	task automatic readback_scene();
		logic [31:0] rd;
		for (int i = 0; i < NUM_SPRITES; i++)
		begin
			apb_read(ATTR_BASE + 8'(i), rd);
			check_word($sformatf("prdata attr %0d", i), rd, 32'(m_attr[i]));
		end
		for (int i = 0; i < N_PAT; i++)
		begin
			apb_read(PAT_BASE + 8'(i), rd);
			check_word($sformatf("prdata pattern %0d", i), rd, m_pat[i]);
		end
		for (int i = 0; i < N_PAL; i++)
		begin
			apb_read(PAL_BASE + 8'(i), rd);
			check_word($sformatf("prdata palette %0d", i), rd, 32'(m_pal[i]));
		end
	endtask

	// Holes between the regions and everything above the palette
	function automatic logic [7:0] bad_addr();
		if (rnd_range(2) == 0)
			return 8'(8 + rnd_range(24));
		return 8'(80 + rnd_range(176));
	endfunction

	task automatic render_line(input int y);
		@(negedge clk);
		line_start = 1'b1;
		line_y = POS_W'(y);
		@(negedge clk);
		line_start = 1'b0;
		if (!busy)
			stop_run($sformatf("busy did not rise after line_start for line %0d", y));
		while (busy)
			@(negedge clk);
	endtask

	// A second line moves the rendered one onto the display half
	task automatic observe_line(input int y);
		paint_line(y);
		render_line(y);
		render_line(rnd_range(LINE_WIDTH));
		for (int x = 0; x < LINE_WIDTH; x++)
		begin
			@(negedge clk);
			disp_x = POS_W'(x);
			@(negedge clk);
			check_color($sformatf("disp_color x %0d line %0d", x, y), disp_color, exp_line[x]);
		end
	endtask

	initial
	begin
		logic [31:0] rd;
		logic err;
		logic [7:0] bad [N_BAD];
		int sy;
		int sx;

		reset = 1'b1;
		apb_req = '0;
		line_start = 1'b0;
		line_y = '0;
		disp_x = '0;
		repeat (5) @(negedge clk);
		reset = 1'b0;

		// Register readback around writes to unmapped addresses
		random_attrs();
		random_assets();
		load_scene();
		for (int b = 0; b < N_BAD; b++)
		begin
			bad[b] = bad_addr();
			apb_xfer(1'b1, bad[b], rand32(), rd, err);
			check_err($sformatf("pslverr write 0x%h", bad[b]), err, 1'b1);
		end
		readback_scene();
		for (int b = 0; b < N_BAD; b++)
		begin
			apb_xfer(1'b0, bad[b], '0, rd, err);
			check_err($sformatf("pslverr read 0x%h", bad[b]), err, 1'b1);
			check_word($sformatf("prdata read 0x%h", bad[b]), rd, '0);
		end

		// One sprite plus the lines just above and below it
		clear_attrs();
		random_assets();
		sy = 8 + rnd_range(40);
		sx = rnd_range(48);
		m_attr[0] = '{enable: 1'b1, mirror: 1'b0, image: IMG_W'(rnd_range(4)),
			y: POS_W'(sy), x: POS_W'(sx)};
		load_scene();
		for (int y = sy - 1; y <= sy + SPRITE_SIZE; y++)
			observe_line(y);

		// Same sprite mirrored
		m_attr[0].mirror = 1'b1;
		load_scene();
		for (int y = sy; y < sy + SPRITE_SIZE; y++)
			observe_line(y);

		// Overlap with a disabled sprite underneath and one clipped at the edge
		clear_attrs();
		random_assets();
		m_attr[2] = '{enable: 1'b1, mirror: 1'b0, image: 2'd1, y: 6'd30, x: 6'd20};
		m_attr[4] = '{enable: 1'b0, mirror: 1'b0, image: 2'd2, y: 6'd30, x: 6'd22};
		m_attr[5] = '{enable: 1'b1, mirror: 1'b1, image: 2'd3, y: 6'd33, x: 6'd24};
		m_attr[7] = '{enable: 1'b1, mirror: 1'b0, image: 2'd0, y: 6'd30, x: 6'd60};
		load_scene();
		for (int y = 30; y < 38; y++)
			observe_line(y);

		// Random scenes
		for (int sc = 0; sc < RAND_SCENES; sc++)
		begin
			random_attrs();
			random_assets();
			load_scene();
			for (int l = 0; l < RAND_LINES; l++)
				observe_line(rnd_range(LINE_WIDTH));
		end

		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

// File: tb/sprite_engine_assert.sv
`timescale 1ns/100ps

module sprite_engine_assert
	import sprite_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic line_start,
	input logic busy,
	input logic clearing,
	input apb_req_t apb_req,
	input apb_rsp_t apb_rsp,
	input lb_write_t lb_write
);

	// busy only starts in response to a line request
	busy_rise: assert property (@(posedge clk) disable iff (reset)
		$rose(busy) |-> $past(line_start))
		else $error("busy rose without line_start in the previous cycle");

	// A response belongs to an access phase that follows its setup cycle
	apb_phase: assert property (@(posedge clk) disable iff (reset)
		(apb_rsp.pready || apb_rsp.pslverr) |->
			(apb_req.psel && apb_req.penable && $past(apb_req.psel && !apb_req.penable)))
		else $error("pready or pslverr outside the APB access phase");

	// Writes land only between the clear and the end of the line
	lb_write_window: assert property (@(posedge clk) disable iff (reset)
		lb_write.we |-> (busy && !clearing))
		else $error("line buffer write while idle or clearing");

endmodule

bind sprite_engine sprite_engine_assert i_sprite_engine_assert (
	.clk, .reset, .line_start, .busy, .clearing, .apb_req, .apb_rsp, .lb_write
);

// File: logic/sprite_engine.sv
`timescale 1ns/100ps

module sprite_engine
	import sprite_pkg::*;
#(
	parameter int NUM_SPRITES = DEFAULT_NUM_SPRITES,
	parameter int LINE_WIDTH = DEFAULT_LINE_WIDTH
)(
	input  logic clk,
	input  logic reset,
	input  apb_req_t apb_req,
	output apb_rsp_t apb_rsp,
	input  logic line_start,
	input  logic [POS_W-1:0] line_y,
	output logic busy,
	input  logic [POS_W-1:0] disp_x,
	output logic [COLOR_W-1:0] disp_color
);

	logic [$clog2(NUM_SPRITES)-1:0] attr_idx;
	sprite_attr_t attr_rd;
	logic [PAT_ADDR_W-1:0] pattern_addr;
	pattern_row_t pattern_rd;
	logic [PIX_W-1:0] palette_idx;
	logic [COLOR_W-1:0] palette_rd;
	span_t span;
	logic span_valid;
	logic span_ready;
	logic draw_idle;
	logic swap;
	logic clearing;
	lb_write_t lb_write;

	// CPU-side storage
	sprite_regs_apb #(.NUM_SPRITES(NUM_SPRITES)) i_regs (
		.clk, .reset, .apb_req, .apb_rsp,
		.attr_idx, .attr_rd,
		.pattern_addr, .pattern_rd,
		.palette_idx, .palette_rd
	);

	sprite_scanner #(.NUM_SPRITES(NUM_SPRITES)) i_scanner (
		.clk, .reset, .line_start, .line_y, .attr_rd, .clearing,
		.span_ready, .draw_idle, .attr_idx, .span, .span_valid, .swap, .busy
	);

	pixel_writer #(.LINE_WIDTH(LINE_WIDTH)) i_writer (
		.clk, .reset, .span, .span_valid, .pattern_rd, .palette_rd,
		.span_ready, .pattern_addr, .palette_idx, .lb_write, .draw_idle
	);

	// Double-buffered line RAM feeding the display
	line_buffer #(.LINE_WIDTH(LINE_WIDTH)) i_line_buffer (
		.clk, .reset, .swap, .lb_write, .disp_x, .clearing, .disp_color
	);

endmodule

// File: logic/line_buffer.sv
`timescale 1ns/100ps

module line_buffer
	import sprite_pkg::*;
#(
	parameter int LINE_WIDTH = DEFAULT_LINE_WIDTH
)(
	input  logic clk,
	input  logic reset,
	input  logic swap,
	input  lb_write_t lb_write,
	input  logic [POS_W-1:0] disp_x,
	output logic clearing,
	output logic [COLOR_W-1:0] disp_color
);

	logic [COLOR_W-1:0] mem [2][LINE_WIDTH];
	logic sel;
	logic [POS_W-1:0] clr_addr;

	// sel is the half being drawn, display reads the other one
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			sel <= 1'b0;
			clearing <= 1'b0;
			clr_addr <= '0;
			disp_color <= '0;
		end
		else
		begin
			disp_color <= mem[~sel][disp_x];
			if (swap)
			begin
				sel <= ~sel;
				clearing <= 1'b1;
				clr_addr <= '0;
			end
			else if (clearing)
			begin
				clr_addr <= clr_addr + 1'b1;
				if (clr_addr == POS_W'(LINE_WIDTH - 1))
					clearing <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (clearing)
			mem[sel][clr_addr] <= '0;
		else if (lb_write.we)
			mem[sel][lb_write.x] <= lb_write.color;
	end

endmodule

// File: logic/pixel_writer.sv
`timescale 1ns/100ps

module pixel_writer
	import sprite_pkg::*;
#(
	parameter int LINE_WIDTH = DEFAULT_LINE_WIDTH
)(
	input  logic clk,
	input  logic reset,
	input  span_t span,
	input  logic span_valid,
	input  pattern_row_t pattern_rd,
	input  logic [COLOR_W-1:0] palette_rd,
	output logic span_ready,
	output logic [PAT_ADDR_W-1:0] pattern_addr,
	output logic [PIX_W-1:0] palette_idx,
	output lb_write_t lb_write,
	output logic draw_idle
);

	writer_state_t state;
	span_t cur;
	logic [ROW_W-1:0] col;
	logic [ROW_W-1:0] src_col;
	logic [PIX_W-1:0] pix;
	logic [POS_W:0] px;
	logic pend_we;
	logic [POS_W-1:0] pend_x;

	assign span_ready = state == WR_IDLE;
	// Idle once the last palette lookup has been written out
	assign draw_idle = (state == WR_IDLE) && !pend_we;
	assign pattern_addr = {cur.image, cur.row};

	// Inverting the column gives 7 - col for an 8-wide sprite
	assign src_col = cur.mirror ? ~col : col;
	assign pix = pattern_rd.pix[src_col];
	assign palette_idx = pix;
	assign px = {1'b0, cur.x} + (POS_W+1)'(col);

	// Palette data arrives one cycle after the index
	assign lb_write = '{we: pend_we, x: pend_x, color: palette_rd};

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= WR_IDLE;
			pend_we <= 1'b0;
		end
		else
		begin
			pend_we <= 1'b0;
			case (state)
				WR_IDLE:
					if (span_valid)
						state <= WR_FETCH;
				WR_FETCH:
					state <= WR_DRAW;
				WR_DRAW:
				begin
					// Index 0 is transparent, past the edge is clipped
					pend_we <= (pix != '0) && (px < (POS_W+1)'(LINE_WIDTH));
					if (col == '1)
						state <= WR_IDLE;
				end
				default:
					state <= WR_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == WR_IDLE && span_valid)
			cur <= span;
		if (state == WR_FETCH)
			col <= '0;
		else if (state == WR_DRAW)
			col <= col + 1'b1;
		pend_x <= px[POS_W-1:0];
	end

endmodule

// File: logic/sprite_scanner.sv
`timescale 1ns/100ps

module sprite_scanner
	import sprite_pkg::*;
#(
	parameter int NUM_SPRITES = DEFAULT_NUM_SPRITES
)(
	input  logic clk,
	input  logic reset,
	input  logic line_start,
	input  logic [POS_W-1:0] line_y,
	input  sprite_attr_t attr_rd,
	input  logic clearing,
	input  logic span_ready,
	input  logic draw_idle,
	output logic [$clog2(NUM_SPRITES)-1:0] attr_idx,
	output span_t span,
	output logic span_valid,
	output logic swap,
	output logic busy
);

	localparam int IDX_W = $clog2(NUM_SPRITES);

	scan_state_t state;
	logic [POS_W-1:0] cur_y;
	logic [POS_W:0] y_end;
	logic hit;
	logic last;

	// One extra bit so sprites near the bottom do not wrap
	assign y_end = {1'b0, attr_rd.y} + (POS_W+1)'(SPRITE_SIZE);
	assign hit = attr_rd.enable && (cur_y >= attr_rd.y) && ({1'b0, cur_y} < y_end);
	assign last = attr_idx == IDX_W'(NUM_SPRITES - 1);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= SCAN_IDLE;
			busy <= 1'b0;
			swap <= 1'b0;
			span_valid <= 1'b0;
			attr_idx <= '0;
		end
		else
		begin
			swap <= 1'b0;
			case (state)
				SCAN_IDLE:
					if (line_start)
					begin
						busy <= 1'b1;
						swap <= 1'b1;
						attr_idx <= '0;
						state <= SCAN_CLEAR_WAIT;
					end
				// Clearing only rises the cycle after swap
				SCAN_CLEAR_WAIT:
					if (!swap && !clearing)
						state <= SCAN_READ_ATTR;
				SCAN_READ_ATTR:
					state <= SCAN_CHECK;
				SCAN_CHECK:
					if (hit)
					begin
						span_valid <= 1'b1;
						state <= SCAN_ISSUE;
					end
					else if (last)
						state <= SCAN_DONE;
					else
					begin
						attr_idx <= attr_idx + 1'b1;
						state <= SCAN_READ_ATTR;
					end
				SCAN_ISSUE:
					if (span_ready)
					begin
						span_valid <= 1'b0;
						if (last)
							state <= SCAN_DONE;
						else
						begin
							attr_idx <= attr_idx + 1'b1;
							state <= SCAN_READ_ATTR;
						end
					end
				// Hold busy until the writer has drained
				SCAN_DONE:
					if (draw_idle)
					begin
						busy <= 1'b0;
						state <= SCAN_IDLE;
					end
				default:
					state <= SCAN_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == SCAN_IDLE && line_start)
			cur_y <= line_y;
		if (state == SCAN_CHECK)
			span <= '{
				x: attr_rd.x,
				mirror: attr_rd.mirror,
				image: attr_rd.image,
				row: ROW_W'(cur_y - attr_rd.y)
			};
	end

endmodule

// File: logic/sprite_regs_apb.sv
`timescale 1ns/100ps

module sprite_regs_apb
	import sprite_pkg::*;
#(
	parameter int NUM_SPRITES = DEFAULT_NUM_SPRITES
)(
	input  logic clk,
	input  logic reset,
	input  apb_req_t apb_req,
	output apb_rsp_t apb_rsp,
	input  logic [$clog2(NUM_SPRITES)-1:0] attr_idx,
	output sprite_attr_t attr_rd,
	input  logic [PAT_ADDR_W-1:0] pattern_addr,
	output pattern_row_t pattern_rd,
	input  logic [PIX_W-1:0] palette_idx,
	output logic [COLOR_W-1:0] palette_rd
);

	localparam int IDX_W = $clog2(NUM_SPRITES);
	localparam logic [7:0] ATTR_END = ATTR_BASE + 8'(NUM_SPRITES);

	sprite_attr_t attr_mem [NUM_SPRITES];
	pattern_row_t pat_mem [2**PAT_ADDR_W];
	logic [COLOR_W-1:0] pal_mem [2**PIX_W];

	logic access;
	logic wr_en;
	logic in_attr;
	logic in_pat;
	logic in_pal;
	logic mapped;
	logic [31:0] rdata;

	// Zero wait states, so the access phase always completes
	assign access = apb_req.psel && apb_req.penable;
	assign wr_en = access && apb_req.pwrite;

	// Region decode
	assign in_attr = apb_req.paddr < ATTR_END;
	assign in_pat = apb_req.paddr[7:PAT_ADDR_W] == PAT_BASE[7:PAT_ADDR_W];
	assign in_pal = apb_req.paddr[7:PIX_W] == PAL_BASE[7:PIX_W];
	assign mapped = in_attr || in_pat || in_pal;

	always_ff @(posedge clk)
	begin
		if (wr_en && in_attr)
			attr_mem[apb_req.paddr[IDX_W-1:0]] <= apb_req.pwdata[$bits(sprite_attr_t)-1:0];
		if (wr_en && in_pat)
			pat_mem[apb_req.paddr[PAT_ADDR_W-1:0]] <= apb_req.pwdata;
		if (wr_en && in_pal)
			pal_mem[apb_req.paddr[PIX_W-1:0]] <= apb_req.pwdata[COLOR_W-1:0];
	end

	// Readback, zero-extended; unmapped reads return zero
	always_comb
	begin
		rdata = '0;
		if (in_attr)
			rdata = 32'(attr_mem[apb_req.paddr[IDX_W-1:0]]);
		else if (in_pat)
			rdata = pat_mem[apb_req.paddr[PAT_ADDR_W-1:0]];
		else if (in_pal)
			rdata = 32'(pal_mem[apb_req.paddr[PIX_W-1:0]]);
	end

	assign apb_rsp = '{
		prdata: rdata,
		pready: access,
		pslverr: access && !mapped
	};

	// Renderer read ports, one cycle latency each
	always_ff @(posedge clk)
	begin
		attr_rd <= attr_mem[attr_idx];
		pattern_rd <= pat_mem[pattern_addr];
		palette_rd <= pal_mem[palette_idx];
	end

endmodule

// File: logic/sprite_pkg.sv
package sprite_pkg;

	// Defaults for the top-level parameters
	localparam int DEFAULT_NUM_SPRITES = 8;
	localparam int DEFAULT_LINE_WIDTH = 64;

	// Sprites are fixed 8x8
	localparam int SPRITE_SIZE = 8;
	localparam int POS_W = 6;
	localparam int IMG_W = 2;
	localparam int COLOR_W = 12;
	localparam int PIX_W = 4;
	localparam int ROW_W = $clog2(SPRITE_SIZE);
	localparam int PAT_ADDR_W = IMG_W + ROW_W;

	// APB word address map
	localparam logic [7:0] ATTR_BASE = 8'h00;
	localparam logic [7:0] PAT_BASE = 8'h20;
	localparam logic [7:0] PAL_BASE = 8'h40;

	typedef struct packed {
		logic enable;
		logic mirror;
		logic [IMG_W-1:0] image;
		logic [POS_W-1:0] y;
		logic [POS_W-1:0] x;
	} sprite_attr_t;

	// Column 0 sits in the low nibble
	typedef struct packed {
		logic [SPRITE_SIZE-1:0][PIX_W-1:0] pix;
	} pattern_row_t;

	typedef struct packed {
		logic [POS_W-1:0] x;
		logic mirror;
		logic [IMG_W-1:0] image;
		logic [ROW_W-1:0] row;
	} span_t;

	typedef struct packed {
		logic we;
		logic [POS_W-1:0] x;
		logic [COLOR_W-1:0] color;
	} lb_write_t;

	typedef struct packed {
		logic psel;
		logic penable;
		logic pwrite;
		logic [7:0] paddr;
		logic [31:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [31:0] prdata;
		logic pready;
		logic pslverr;
	} apb_rsp_t;

	typedef enum logic [2:0] {
		SCAN_IDLE,
		SCAN_CLEAR_WAIT,
		SCAN_READ_ATTR,
		SCAN_CHECK,
		SCAN_ISSUE,
		SCAN_DONE
	} scan_state_t;

	typedef enum logic [1:0] {
		WR_IDLE,
		WR_FETCH,
		WR_DRAW
	} writer_state_t;

endpackage
